// ==== serial_alu.f ====
hdl/nibble_alu_pkg.sv
hdl/nibble_step_if.sv
hdl/nibble_alu.sv
hdl/nibble_counter.sv
hdl/nibble_loop_fsm.sv
hdl/nibble_result_reg.sv
hdl/serial_alu.sv
verif/serial_alu_assertions.sv
verif/serial_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the serial_alu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module serial_alu_tb -Mdir obj_dir -f serial_alu.f

sim_out=$(./obj_dir/Vserial_alu_tb +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== verif/serial_alu_tb.sv ====
// testbench for serial_alu with LFSR stimulus, reference model, compare task and done timeouts
`timescale 1ns/1ps
`default_nettype none

module serial_alu_tb;

    localparam int op_timeout = 16;

    logic                     clk;
    logic                     rst_n;
    logic                     start;
    nibble_alu_pkg::alu_cmd_t cmd;
    logic [2:0]               width;
    logic                     b_signed;
    logic [31:0]              word1;
    logic [31:0]              word2;
    logic [31:0]              preinit;
    logic                     busy;
    logic                     done;
    logic [31:0]              result;
    logic                     carry_out;

    logic [31:0]              lfsr_q = 32'h9e9b_5b37;

    serial_alu serial_alu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cmd       (cmd),
        .width     (width),
        .b_signed  (b_signed),
        .word1     (word1),
        .word2     (word2),
        .preinit   (preinit),
        .busy      (busy),
        .done      (done),
        .result    (result),
        .carry_out (carry_out)
    );

    bind serial_alu serial_alu_assertions assertions_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .busy  (busy),
        .done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // ones over the nibbles 0 to w
    function automatic logic [31:0] width_mask(input logic [2:0] w);
        return 32'hFFFF_FFFF >> (28 - 4 * int'(w));
    endfunction

    // bit 32 is the carry, bits 31:0 the result
    function automatic logic [32:0] model(input nibble_alu_pkg::alu_cmd_t c, input logic [2:0] w,
                                          input logic bs, input logic [31:0] a,
                                          input logic [31:0] b, input logic [31:0] p);
        logic [31:0] mask;
        logic [31:0] b_ext;
        logic [32:0] sum;
        mask  = width_mask(w);
        b_ext = bs ? (b | ~mask) : (b & mask);
        case (c)
            nibble_alu_pkg::ADD: sum = {1'b0, a} + {1'b0, b_ext};
            nibble_alu_pkg::SUB: sum = {1'b0, a} + {1'b0, ~b_ext} + 33'd1;
            default:             sum = {1'b0, (p & ~mask) | ((b & mask) >> 1)};
        endcase
        return sum;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // one operation, optionally with a second start pulse while busy
    task automatic run_op(input string name, input nibble_alu_pkg::alu_cmd_t c,
                          input logic [2:0] w, input logic bs, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] p, input logic poke);
        logic [32:0] expected;
        logic [31:0] upper;
        int          exp_busy;
        int          busy_cnt;
        int          cycles;
        logic        done_seen;
        expected  = model(c, w, bs, a, b, p);
        upper     = ~width_mask(w);
        exp_busy  = (c == nibble_alu_pkg::RSHFT) ? int'(w) + 1 : nibble_alu_pkg::nibbles;
        busy_cnt  = 0;
        cycles    = 0;
        done_seen = 1'b0;
        @(posedge clk);
        start    <= 1'b1;
        cmd      <= c;
        width    <= w;
        b_signed <= bs;
        word1    <= a;
        word2    <= b;
        preinit  <= p;
        while (!done_seen) begin
            @(posedge clk);
            start <= 1'b0;
            if (poke && busy_cnt == 2) begin
                // other operands that must not be taken
                start    <= 1'b1;
                cmd      <= nibble_alu_pkg::RSHFT;
                width    <= ~w;
                b_signed <= ~bs;
                word1    <= ~a;
                word2    <= ~b;
                preinit  <= ~p;
            end
            @(negedge clk);
            cycles++;
            if (done) begin
                done_seen = 1'b1;
            end else if (busy) begin
                busy_cnt++;
            end
            if (!done_seen && cycles > op_timeout) begin
                $display("timeout in %s, done never arrived after %0d cycles", name, cycles);
                $display("TESTS FAILED");
                $fatal(1, "done timeout");
            end
        end
        // nibbles above the width keep preinit
        if (c == nibble_alu_pkg::RSHFT) begin
            compare({name, " upper nibbles"}, p & upper, result & upper);
        end
        compare({name, " result"}, expected[31:0], result);
        compare({name, " carry"}, {31'd0, expected[32]}, {31'd0, carry_out});
        compare({name, " busy cycles"}, 32'(exp_busy), 32'(busy_cnt));
        // done is a single pulse and nothing restarts afterwards
        repeat (2) begin
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
            compare({name, " done after pulse"}, 32'd0, {31'd0, done});
            compare({name, " busy after pulse"}, 32'd0, {31'd0, busy});
        end
    endtask

    initial begin
        logic [2:0]  w;
        logic        bs;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        rst_n    = 1'b0;
        start    = 1'b0;
        cmd      = nibble_alu_pkg::ADD;
        width    = 3'd0;
        b_signed = 1'b0;
        word1    = 32'd0;
        word2    = 32'd0;
        preinit  = 32'd0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare("reset result", 32'd0, result);
        compare("reset carry", 32'd0, {31'd0, carry_out});
        compare("reset busy", 32'd0, {31'd0, busy});
        compare("reset done", 32'd0, {31'd0, done});

        for (int i = 0; i < 20; i++) begin
            bs = 1'(rand_bits(1));
            a  = rand_bits(32);
            b  = rand_bits(32);
            run_op("add full", nibble_alu_pkg::ADD, 3'd7, bs, a, b, 32'd0, 1'b0);
        end

        for (int i = 0; i < 20; i++) begin
            w = 3'(rand_bits(3));
            a = rand_bits(32);
            b = rand_bits(32);
            run_op("sub", nibble_alu_pkg::SUB, w, 1'(i % 2), a, b, 32'd0, 1'b0);
        end

        for (int i = 0; i < 20; i++) begin
            w = 3'(rand_bits(3) % 7);
            a = rand_bits(32);
            b = rand_bits(32);
            run_op("add sign fill", nibble_alu_pkg::ADD, w, 1'b1, a, b, 32'd0, 1'b0);
        end

        for (int i = 0; i < 20; i++) begin
            w = 3'(rand_bits(3));
            a = rand_bits(32);
            b = rand_bits(32);
            p = rand_bits(32);
            run_op("rshft", nibble_alu_pkg::RSHFT, w, 1'b0, a, b, p, 1'b0);
        end

        for (int i = 0; i < 10; i++) begin
            w  = 3'(rand_bits(3));
            bs = 1'(rand_bits(1));
            a  = rand_bits(32);
            b  = rand_bits(32);
            if (i % 2 == 0) begin
                run_op("start while busy add", nibble_alu_pkg::ADD, w, bs, a, b, 32'd0, 1'b1);
            end else begin
                run_op("start while busy sub", nibble_alu_pkg::SUB, w, bs, a, b, 32'd0, 1'b1);
            end
        end

        if (serial_alu_inst.assertions_inst.error_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "assertion errors seen");
        end
    end

endmodule

`default_nettype wire

// ==== verif/serial_alu_assertions.sv ====
// concurrent checks on the busy and done outputs of serial_alu
`timescale 1ns/1ps
`default_nettype none

module serial_alu_assertions (
    input wire clk,
    input wire rst_n,
    input wire busy,
    input wire done
);

    int error_count = 0;

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done held for more than one cycle");
            error_count++;
        end

    done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) !(done && busy))
        else begin
            $error("done and busy high together");
            error_count++;
        end

    // first edge out of reset
    idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> (!busy && !done))
        else begin
            $error("busy or done high after reset");
            error_count++;
        end

endmodule

`default_nettype wire

// ==== hdl/serial_alu.sv ====
// top level of the nibble-serial ALU with FSM, counter and datapath joined by the step interface
`timescale 1ns/1ps
`default_nettype none

module serial_alu (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               start,
    input  nibble_alu_pkg::alu_cmd_t          cmd,
    // operand width as nibble count minus one
    input  wire [2:0]                         width,
    input  wire                               b_signed,
    input  wire [nibble_alu_pkg::word_w-1:0]  word1,
    input  wire [nibble_alu_pkg::word_w-1:0]  word2,
    input  wire [nibble_alu_pkg::word_w-1:0]  preinit,
    output logic                              busy,
    output logic                              done,
    output logic [nibble_alu_pkg::word_w-1:0] result,
    output logic                              carry_out
);

    nibble_step_if step_if ();

    nibble_loop_fsm fsm_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .busy  (busy),
        .done  (done),
        .step  (step_if.fsm)
    );

    // counter and datapath each latch cmd on load
    nibble_counter counter_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .width (width),
        .step  (step_if.cnt)
    );

    nibble_result_reg result_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .b_signed  (b_signed),
        .word1     (word1),
        .word2     (word2),
        .preinit   (preinit),
        .result    (result),
        .carry_out (carry_out),
        .step      (step_if.dat)
    );

endmodule

`default_nettype wire

// ==== hdl/nibble_result_reg.sv ====
// result word and carry registers, operand nibble selection and the ALU slice
`timescale 1ns/1ps
`default_nettype none

module nibble_result_reg (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  nibble_alu_pkg::alu_cmd_t             cmd,
    input  wire                                  b_signed,
    input  wire [nibble_alu_pkg::word_w-1:0]     word1,
    input  wire [nibble_alu_pkg::word_w-1:0]     word2,
    input  wire [nibble_alu_pkg::word_w-1:0]     preinit,
    output logic [nibble_alu_pkg::word_w-1:0]    result,
    output logic                                 carry_out,
    nibble_step_if.dat                           step
);

    nibble_alu_pkg::alu_cmd_t              cmd_q;
    logic                                  b_signed_q;
    logic [nibble_alu_pkg::word_w-1:0]     word1_q;
    logic [nibble_alu_pkg::word_w-1:0]     word2_q;

    // carry between forward steps, shifted-out bit between RSHFT steps
    logic                                  carry_q;

    logic [nibble_alu_pkg::nibble_w-1:0]   d2_raw;
    nibble_alu_pkg::alu_args_t             alu_args;
    nibble_alu_pkg::alu_ret_t              alu_ret;

    always_ff @(posedge clk) begin
        if (step.load) begin
            cmd_q      <= cmd;
            b_signed_q <= b_signed;
            word1_q    <= word1;
            word2_q    <= word2;
        end
    end

    assign d2_raw = word2_q[step.idx*nibble_alu_pkg::nibble_w +: nibble_alu_pkg::nibble_w];

    always_comb begin
        alu_args.cmd      = cmd_q;
        alu_args.carry_in = carry_q;
        alu_args.b_inv    = (cmd_q == nibble_alu_pkg::SUB);
        alu_args.d1       = word1_q[step.idx*nibble_alu_pkg::nibble_w +: nibble_alu_pkg::nibble_w];
        // sign fill above the width, inverted afterwards for SUB
        if (step.past_width) begin
            alu_args.d2 = {nibble_alu_pkg::nibble_w{b_signed_q}};
        end else begin
            alu_args.d2 = d2_raw;
        end
        // the top visited nibble sees a 0 since carry_q is cleared on load
        alu_args.d2_next_lsb = carry_q;
    end

    nibble_alu alu_inst (
        .args (alu_args),
        .ret  (alu_ret)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result    <= '0;
            carry_q   <= 1'b0;
            carry_out <= 1'b0;
        end else if (step.load) begin
            result    <= preinit;
            carry_q   <= (cmd == nibble_alu_pkg::SUB);
            carry_out <= 1'b0;
        end else if (step.step_en) begin
            result[step.idx*nibble_alu_pkg::nibble_w +: nibble_alu_pkg::nibble_w] <= alu_ret.res;
            carry_q <= step.reverse ? d2_raw[0] : alu_ret.carry_out;
            if (step.last && !step.reverse) begin
                carry_out <= alu_ret.carry_out;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/nibble_loop_fsm.sv ====
// sequencer FSM stepping through load, run and done
`timescale 1ns/1ps
`default_nettype none

module nibble_loop_fsm (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         start,
    output logic        busy,
    output logic        done,
    nibble_step_if.fsm  step
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } state_t;

    state_t state;
    state_t state_next;

    // start only counts while idle, it also loads the datapath in this cycle
    assign step.load    = (state == IDLE) && start;
    assign step.step_en = (state == RUN);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                // the step where last is high is the final one
                if (step.last) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign busy = (state == RUN);
    assign done = (state == DONE);

endmodule

`default_nettype wire

// ==== hdl/nibble_counter.sv ====
// nibble index counter with direction, last-nibble and past-width detection
`timescale 1ns/1ps
`default_nettype none

module nibble_counter (
    input  wire                     clk,
    input  wire                     rst_n,
    input  nibble_alu_pkg::alu_cmd_t cmd,
    input  wire [2:0]               width,
    nibble_step_if.cnt              step
);

    // command and width held for the whole operation
    nibble_alu_pkg::alu_cmd_t          cmd_q;
    logic [2:0]                        width_q;
    logic [nibble_alu_pkg::idx_w-1:0]  idx_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q   <= nibble_alu_pkg::ADD;
            width_q <= '0;
        end else if (step.load) begin
            cmd_q   <= cmd;
            width_q <= width;
        end
    end

    // RSHFT starts at the top visited nibble, forward commands at nibble 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
        end else if (step.load) begin
            idx_q <= (cmd == nibble_alu_pkg::RSHFT) ? width : '0;
        end else if (step.step_en) begin
            if (step.reverse) begin
                idx_q <= idx_q - 1'b1;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    assign step.idx     = idx_q;
    assign step.reverse = (cmd_q == nibble_alu_pkg::RSHFT);

    // forward commands always walk every nibble, width only affects sign fill
    assign step.last = step.reverse ? (idx_q == '0)
                                    : (idx_q == {nibble_alu_pkg::idx_w{1'b1}});

    assign step.past_width = (idx_q > width_q);

endmodule

`default_nettype wire

// ==== hdl/nibble_alu.sv ====
// combinational 4-bit ALU slice for add, subtract and one-bit right shift
`timescale 1ns/1ps
`default_nettype none

module nibble_alu (
    input  nibble_alu_pkg::alu_args_t args,
    output nibble_alu_pkg::alu_ret_t  ret
);

    // second operand after optional inversion
    logic [nibble_alu_pkg::nibble_w-1:0] d2_eff;

    // sum with the carry as its top bit
    logic [nibble_alu_pkg::nibble_w:0]   sum;

    // SUB is an add of the inverted operand with carry_in set by the caller
    always_comb begin
        d2_eff = args.b_inv ? ~args.d2 : args.d2;
    end

    always_comb begin
        sum = {1'b0, args.d1}
            + {1'b0, d2_eff}
            + {{nibble_alu_pkg::nibble_w{1'b0}}, args.carry_in};
    end

    always_comb begin
        ret = '0;
        case (args.cmd)
            nibble_alu_pkg::RSHFT: begin
                // the neighbour's bit 0 enters at the top
                ret.res       = {args.d2_next_lsb, args.d2[nibble_alu_pkg::nibble_w-1:1]};
                ret.carry_out = 1'b0;
            end
            nibble_alu_pkg::ADD,
            nibble_alu_pkg::SUB: begin
                ret.res       = sum[nibble_alu_pkg::nibble_w-1:0];
                ret.carry_out = sum[nibble_alu_pkg::nibble_w];
            end
            default: begin
                ret = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/nibble_step_if.sv ====
// per-step control interface between the sequencer FSM, the nibble counter and the datapath
`timescale 1ns/1ps
`default_nettype none

interface nibble_step_if;

    // from the FSM
    logic                             load;
    logic                             step_en;

    // from the counter
    logic [nibble_alu_pkg::idx_w-1:0] idx;
    logic                             last;
    // idx lies above the operand width
    logic                             past_width;
    // high while an RSHFT walks from the top nibble down
    logic                             reverse;

    modport fsm (
        output load,
        output step_en,
        input  last
    );

    modport cnt (
        input  load,
        input  step_en,
        output idx,
        output last,
        output past_width,
        output reverse
    );

    modport dat (
        input load,
        input step_en,
        input idx,
        input last,
        input past_width,
        input reverse
    );

endinterface

`default_nettype wire

// ==== hdl/nibble_alu_pkg.sv ====
// nibble ALU package with sizes, command encoding and ALU argument and return structs
`default_nettype none

package nibble_alu_pkg;

    // one ALU slice works on a nibble, a word holds eight of them
    localparam int nibble_w = 4;
    localparam int nibbles  = 8;
    localparam int word_w   = nibble_w * nibbles;

    // width of the nibble index
    localparam int idx_w = $clog2(nibbles);

    // ADD and SUB run from nibble 0 upwards, RSHFT runs from the top nibble down
    typedef enum logic [1:0] {
        ADD   = 2'd0,
        SUB   = 2'd1,
        RSHFT = 2'd2
    } alu_cmd_t;

    // inputs of one slice step
    typedef struct packed {
        alu_cmd_t              cmd;
        logic                  carry_in;
        // invert d2 before the add, used for SUB
        logic                  b_inv;
        logic [nibble_w-1:0]   d1;
        logic [nibble_w-1:0]   d2;
        // bit shifted into the top of the nibble on RSHFT
        logic                  d2_next_lsb;
    } alu_args_t;

    // outputs of one slice step
    typedef struct packed {
        logic [nibble_w-1:0]   res;
        logic                  carry_out;
    } alu_ret_t;

endpackage

`default_nettype wire
